// File: verilog/hsi_settings.svh
`ifndef HSI_SETTINGS_SVH
`define HSI_SETTINGS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// line timing and frame scheduling
`define BIT_DIV     4           // clk cycles per line bit
`define TM_PER_BTC  3           // tm frames per btc frame

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// frame codes
`define HDR_TM      8'h1e       // telemetry header
`define HDR_BTC     8'h2d       // time code header

`define CRC_INIT    16'hffff    // ccitt seed

`endif

// File: verilog/hsi_line_pkg.sv
package hsi_line_pkg;

	// one character on the line
	typedef logic [7:0] line_byte_t;

	// crc word, also the payload of the crc frame
	typedef logic [15:0] crc_t;

endpackage

// File: verilog/hsi_frame_pkg.sv
package hsi_frame_pkg;

	// arbiter state
	typedef enum logic [1:0]
	{
		st_idle,
		st_sending_tm,
		st_sending_btc,
		st_sending_crc
	} frame_state_e;

	// header goes out first, so it sits in the top bits
	typedef struct packed
	{
		logic [7:0]  hdr;
		logic [31:0] word;
	} tm_frame_t;

	typedef struct packed
	{
		logic [7:0]  hdr;
		logic [39:0] time_code;
	} btc_frame_t;

endpackage

// File: verilog/clk_en_ctrl.sv
`timescale 1ns/1ps

`include "hsi_settings.svh"

module clk_en_ctrl (
	input  logic clk,
	input  logic n_rst,
	output logic bit_en
);

	localparam int CNT_W = $clog2(`BIT_DIV + 1);

	logic [CNT_W-1:0] cnt;

	always_ff @(posedge clk or negedge n_rst)
	begin
		if (!n_rst)
			cnt <= '0;
		else if (bit_en)
			cnt <= '0;                          // wrap
		else
			cnt <= cnt + 1'b1;
	end

	assign bit_en = (cnt == CNT_W'(`BIT_DIV - 1));

endmodule

// File: verilog/msg_sender.sv
`timescale 1ns/1ps

module msg_sender import hsi_line_pkg::*; #(
	parameter type payload_t = line_byte_t
) (
	input  logic       clk,
	input  logic       n_rst,
	input  logic       load,
	input  payload_t   payload,
	output logic       byte_valid,
	output line_byte_t byte_data,
	input  logic       byte_ready,
	output logic       done
);

	localparam int PAY_W   = $bits(payload_t);
	localparam int N_BYTES = PAY_W / 8;
	localparam int CNT_W   = $clog2(N_BYTES + 1);

	logic [PAY_W-1:0] shreg;
	logic [CNT_W-1:0] bytes_left;
	logic             xfer;

	assign xfer = byte_valid && byte_ready;

	always_ff @(posedge clk or negedge n_rst)
	begin
		if (!n_rst)
			bytes_left <= '0;
		else if (load)
			bytes_left <= CNT_W'(N_BYTES);
		else if (xfer)
			bytes_left <= bytes_left - 1'b1;
	end

	// msb first
	always_ff @(posedge clk)
	begin
		if (load)
			shreg <= payload;
		else if (xfer)
			shreg <= shreg << 8;
	end

	assign byte_valid = (bytes_left != '0);
	assign byte_data  = shreg[PAY_W-1 -: 8];
	assign done       = xfer && (bytes_left == CNT_W'(1));     // last byte taken

	// a new frame is only loaded once the previous one has drained
	a_no_load_busy: assert property (
		@(posedge clk) disable iff (!n_rst) load |-> !byte_valid
	);

endmodule

// File: verilog/btc_sched.sv
`timescale 1ns/1ps

`include "hsi_settings.svh"

module btc_sched (
	input  logic        clk,
	input  logic        n_rst,
	input  logic        tm_frame_end,
	input  logic        btc_en,
	input  logic [39:0] btc,
	output logic        btc_req,
	output logic [39:0] btc_time,
	input  logic        btc_taken
);

	localparam int CNT_W = $clog2(`TM_PER_BTC + 1);

	logic [CNT_W-1:0] tm_cnt;
	logic             period_hit;

	assign period_hit = tm_frame_end && (tm_cnt == CNT_W'(`TM_PER_BTC - 1));

	always_ff @(posedge clk or negedge n_rst)
	begin
		if (!n_rst)
		begin
			tm_cnt  <= '0;
			btc_req <= 1'b0;
		end
		else
		begin
			if (period_hit)
				tm_cnt <= '0;
			else if (tm_frame_end)
				tm_cnt <= tm_cnt + 1'b1;

			if (period_hit && btc_en)
				btc_req <= 1'b1;                // sticky until taken
			else if (btc_taken)
				btc_req <= 1'b0;
		end
	end

	always_ff @(posedge clk)
	begin
		if (period_hit && btc_en)
			btc_time <= btc;                    // time code at frame end
	end

endmodule

// File: verilog/crc16_ccitt.sv
`timescale 1ns/1ps

`include "hsi_settings.svh"

module crc16_ccitt import hsi_line_pkg::*; (
	input  logic       clk,
	input  logic       n_rst,
	input  logic       clear,
	input  logic       en,
	input  line_byte_t d,
	output crc_t       crc
);

	// poly 0x1021, msb first, one bit per step
	function automatic crc_t crc_byte(input crc_t c, input line_byte_t b);
		crc_t r;
		logic fb;
		r = c;
		for (int i = 7; i >= 0; i--)
		begin
			fb = r[15] ^ b[i];
			r  = {r[14:0], 1'b0};
			if (fb)
				r = r ^ 16'h1021;
		end
		return r;
	endfunction

	always_ff @(posedge clk or negedge n_rst)
	begin
		if (!n_rst)
			crc <= `CRC_INIT;
		else if (clear)
			crc <= `CRC_INIT;               // new frame
		else if (en)
			crc <= crc_byte(crc, d);
	end

endmodule

// File: verilog/bit_coder.sv
`timescale 1ns/1ps

module bit_coder import hsi_line_pkg::*; (
	input  logic       clk,
	input  logic       n_rst,
	input  logic       bit_en,
	input  logic       valid,
	input  line_byte_t data,
	output logic       ready,
	input  logic       com_src,
	output logic       com1,
	output logic       com2
);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// character: start 0, data lsb first, stop 1

	logic [9:0] shreg;
	logic [3:0] bits_left;
	logic       tx_line;
	logic       sel;
	logic       accept;
	logic       shift;

	// ready rises while the stop bit is on the line, so the next
	// start bit follows on the very next bit enable
	assign ready  = (bits_left == 4'd0);
	assign accept = valid && ready;
	assign shift  = bit_en && !ready;

	always_ff @(posedge clk or negedge n_rst)
	begin
		if (!n_rst)
		begin
			bits_left <= 4'd0;
			tx_line   <= 1'b1;              // idle high
			sel       <= 1'b1;
		end
		else if (accept)
		begin
			bits_left <= 4'd10;
		end
		else if (shift)
		begin
			if (bits_left == 4'd10)
				sel <= com_src;             // line fixed per character
			tx_line   <= shreg[0];
			bits_left <= bits_left - 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (accept)
			shreg <= {1'b1, data, 1'b0};
		else if (shift)
			shreg <= {1'b1, shreg[9:1]};
	end

	// unselected line parks high
	assign com1 = sel ? tx_line : 1'b1;
	assign com2 = sel ? 1'b1 : tx_line;

endmodule

// File: verilog/hsi_master.sv
`timescale 1ns/1ps

`include "hsi_settings.svh"

module hsi_master import hsi_frame_pkg::*, hsi_line_pkg::*; (
	input  logic        clk,
	input  logic        n_rst,
	input  logic        tm_valid,
	input  logic [31:0] tm_data,
	output logic        tm_ready,
	input  logic        btc_en,
	input  logic [39:0] btc,
	input  logic        com_src,
	output logic        com1,
	output logic        com2
);

	frame_state_e state;

	logic        bit_en;
	logic        start_tm, start_btc;
	logic        cur_tm;                    // frame in flight is telemetry
	logic        crc_load;
	logic        tm_frame_end;
	logic        btc_req;
	logic [39:0] btc_time;
	crc_t        crc;

	tm_frame_t   tm_frame;
	btc_frame_t  btc_frame;

	logic        tm_bv, btc_bv, crc_bv;
	line_byte_t  tm_bd, btc_bd, crc_bd;
	logic        tm_br, btc_br, crc_br;
	logic        tm_done, btc_done, crc_done;

	logic        cd_valid, cd_ready, xfer;
	line_byte_t  cd_data;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// frame arbiter

	assign tm_ready  = (state == st_idle);
	assign start_tm  = tm_valid && tm_ready;              // tm beats btc
	assign start_btc = tm_ready && !tm_valid && btc_req;

	assign tm_frame  = '{hdr: `HDR_TM, word: tm_data};
	assign btc_frame = '{hdr: `HDR_BTC, time_code: btc_time};

	always_ff @(posedge clk or negedge n_rst)
	begin
		if (!n_rst)
		begin
			state    <= st_idle;
			cur_tm   <= 1'b0;
			crc_load <= 1'b0;
		end
		else
		begin
			crc_load <= tm_done || btc_done;   // crc settles one cycle later
			case (state)
				st_idle:
				begin
					cur_tm <= start_tm;
					if (start_tm)
						state <= st_sending_tm;
					else if (start_btc)
						state <= st_sending_btc;
				end
				st_sending_tm:
					if (tm_done)
						state <= st_sending_crc;
				st_sending_btc:
					if (btc_done)
						state <= st_sending_crc;
				st_sending_crc:
					if (crc_done)
						state <= st_idle;
				default:
					state <= st_idle;
			endcase
		end
	end

	assign tm_frame_end = crc_done && cur_tm;

	// byte mux
	always_comb
	begin
		case (state)
			st_sending_tm:  {cd_valid, cd_data} = {tm_bv, tm_bd};
			st_sending_btc: {cd_valid, cd_data} = {btc_bv, btc_bd};
			st_sending_crc: {cd_valid, cd_data} = {crc_bv, crc_bd};
			default:        {cd_valid, cd_data} = {1'b0, 8'h00};
		endcase
	end

	assign tm_br  = cd_ready && (state == st_sending_tm);
	assign btc_br = cd_ready && (state == st_sending_btc);
	assign crc_br = cd_ready && (state == st_sending_crc);
	assign xfer   = cd_valid && cd_ready;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// instances

	clk_en_ctrl clk_en_ctrl_inst (
		.clk    (clk),
		.n_rst  (n_rst),
		.bit_en (bit_en)
	);

	btc_sched btc_sched_inst (
		.clk          (clk),
		.n_rst        (n_rst),
		.tm_frame_end (tm_frame_end),
		.btc_en       (btc_en),
		.btc          (btc),
		.btc_req      (btc_req),
		.btc_time     (btc_time),
		.btc_taken    (start_btc)
	);

	msg_sender #(.payload_t(tm_frame_t)) tm_sender_inst (
		.clk        (clk),
		.n_rst      (n_rst),
		.load       (start_tm),
		.payload    (tm_frame),
		.byte_valid (tm_bv),
		.byte_data  (tm_bd),
		.byte_ready (tm_br),
		.done       (tm_done)
	);

	msg_sender #(.payload_t(btc_frame_t)) btc_sender_inst (
		.clk        (clk),
		.n_rst      (n_rst),
		.load       (start_btc),
		.payload    (btc_frame),
		.byte_valid (btc_bv),
		.byte_data  (btc_bd),
		.byte_ready (btc_br),
		.done       (btc_done)
	);

	msg_sender #(.payload_t(crc_t)) crc_sender_inst (
		.clk        (clk),
		.n_rst      (n_rst),
		.load       (crc_load),
		.payload    (crc),
		.byte_valid (crc_bv),
		.byte_data  (crc_bd),
		.byte_ready (crc_br),
		.done       (crc_done)
	);

	crc16_ccitt crc16_ccitt_inst (
		.clk   (clk),
		.n_rst (n_rst),
		.clear (start_tm || start_btc),
		.en    (xfer && (state != st_sending_crc)),
		.d     (cd_data),
		.crc   (crc)
	);

	bit_coder bit_coder_inst (
		.clk     (clk),
		.n_rst   (n_rst),
		.bit_en  (bit_en),
		.valid   (cd_valid),
		.data    (cd_data),
		.ready   (cd_ready),
		.com_src (com_src),
		.com1    (com1),
		.com2    (com2)
	);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// checks

	a_one_sender: assert property (
		@(posedge clk) disable iff (!n_rst) $onehot0({tm_bv, btc_bv, crc_bv})
	);

	// leaving the crc state means both crc bytes went to the coder
	a_crc_exit: assert property (
		@(posedge clk) disable iff (!n_rst)
		($past(state) == st_sending_crc && state != st_sending_crc) |-> !crc_bv
	);

endmodule

// File: verification/hsi_tb.sv
`timescale 1ns/1ps

`include "hsi_settings.svh"

module hsi_tb;

	localparam int N_WORDS    = 48;
	localparam int MAX_GAP    = 200;
	localparam int CHAR_CYC   = 10 * `BIT_DIV;
	localparam int QUIET_CYC  = 12 * `BIT_DIV;     // longer than any high run inside a frame
	localparam int MAX_CYCLES = N_WORDS * (2 * 8 * CHAR_CYC + MAX_GAP + 2 * QUIET_CYC) + 4000;

	logic        clk;
	logic        n_rst;
	logic        tm_valid;
	logic [31:0] tm_data;
	logic        tm_ready;
	logic        btc_en;
	logic [39:0] btc;
	logic        com_src;
	logic        com1;
	logic        com2;

	logic [7:0]  exp_q[$];                  // expected line bytes, in order
	int          errors     = 0;
	int          checks     = 0;
	int          tm_frames  = 0;
	int          btc_frames = 0;
	int          quiet_cnt  = 0;            // negedges with both lines high
	int          cycles     = 0;

	// arbiter and time code scheduling model
	logic        ready_q    = 1'b1;
	logic        cur_tm     = 1'b0;
	logic        frame_started = 1'b0;      // a frame was taken on the last edge
	logic        model_req  = 1'b0;
	logic [39:0] model_time = '0;
	int          tm_cnt     = 0;

	hsi_master hsi_master_inst (
		.clk      (clk),
		.n_rst    (n_rst),
		.tm_valid (tm_valid),
		.tm_data  (tm_data),
		.tm_ready (tm_ready),
		.btc_en   (btc_en),
		.btc      (btc),
		.com_src  (com_src),
		.com1     (com1),
		.com2     (com2)
	);

	always #2 clk = ~clk;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// reference model

	function automatic logic [15:0] crc_step(input logic [15:0] c, input logic [7:0] b);
		logic [15:0] r;
		r = c ^ {b, 8'h00};
		for (int k = 0; k < 8; k++)
			r = r[15] ? ((r << 1) ^ 16'h1021) : (r << 1);
		return r;
	endfunction

	task automatic push_frame(input logic [7:0] hdr, input logic [39:0] body, input int n_body);
		logic [15:0] crc;
		logic [7:0]  b;
		crc = `CRC_INIT;
		exp_q.push_back(hdr);
		crc = crc_step(crc, hdr);
		for (int i = n_body - 1; i >= 0; i--)
		begin
			b = body[8*i +: 8];                 // msb first
			exp_q.push_back(b);
			crc = crc_step(crc, b);
		end
		exp_q.push_back(crc[15:8]);
		exp_q.push_back(crc[7:0]);
	endtask

	task automatic expect_bit(input string name, input logic got, input logic want);
		checks++;
		if (got !== want)
		begin
			errors++;
			$display("[ERROR] %s: expected %h, got %h", name, want, got);
		end
	endtask

	// a rise of tm_ready marks the end of the frame on the previous edge
	always @(posedge clk)
	begin
		if (n_rst)
		begin
			if (frame_started)
				expect_bit("tm_ready", tm_ready, 1'b0);    // busy once a frame is taken
			frame_started = 1'b0;
			if (!ready_q && tm_ready && cur_tm)
			begin
				tm_cnt++;
				if (tm_cnt == `TM_PER_BTC)
				begin
					tm_cnt = 0;
					if (btc_en)
					begin
						model_req  = 1'b1;
						model_time = btc;           // a later hit overwrites
					end
				end
			end
			if (tm_ready && tm_valid)
			begin
				push_frame(`HDR_TM, {8'h00, tm_data}, 4);
				cur_tm        = 1'b1;
				frame_started = 1'b1;
				tm_frames++;
			end
			else if (tm_ready && model_req)
			begin
				push_frame(`HDR_BTC, model_time, 5);
				model_req     = 1'b0;
				cur_tm        = 1'b0;
				frame_started = 1'b1;
				btc_frames++;
			end
			ready_q = tm_ready;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// line receiver

	function automatic string line_name(input logic on_com1);
		return on_com1 ? "com1" : "com2";
	endfunction

	// the line not in use stays parked high
	task automatic check_other(input logic on_com1);
		logic other;
		other = on_com1 ? com2 : com1;
		checks++;
		if (other !== 1'b1)
		begin
			errors++;
			$display("[ERROR] %s idle: expected %h, got %h", line_name(!on_com1), 1'b1, other);
		end
	endtask

	task automatic check_bit(input logic on_com1, input string what, input logic want);
		logic got;
		got = on_com1 ? com1 : com2;
		checks++;
		if (got !== want)
		begin
			errors++;
			$display("[ERROR] %s %s: expected %h, got %h", line_name(on_com1), what, want, got);
		end
		check_other(on_com1);
	endtask

	task automatic compare_byte(input logic on_com1, input logic [7:0] got);
		logic [7:0] want;
		checks++;
		if (exp_q.size() == 0)
		begin
			errors++;
			$display("byte %h arrived on %s with no frame expected", got, line_name(on_com1));
		end
		else
		begin
			want = exp_q.pop_front();
			if (got !== want)
			begin
				errors++;
				$display("[ERROR] %s byte: expected %h, got %h", line_name(on_com1), want, got);
			end
		end
	endtask

	initial
	begin : line_receiver
		logic       on_com1;
		logic [7:0] rx_byte;
		forever
		begin
			@(negedge clk);
			if (!n_rst || (com1 && com2))
				quiet_cnt++;
			else
			begin
				quiet_cnt = 0;
				on_com1   = !com1;
				checks++;
				if (on_com1 != com_src)
				begin
					errors++;
					$display("character started on %s while com_src selects %s",
						line_name(on_com1), line_name(com_src));
				end
				repeat (`BIT_DIV / 2) @(negedge clk);     // mid start bit
				check_bit(on_com1, "start bit", 1'b0);
				for (int i = 0; i < 8; i++)
				begin
					repeat (`BIT_DIV) @(negedge clk);
					rx_byte[i] = on_com1 ? com1 : com2;   // lsb first
					check_other(on_com1);
				end
				repeat (`BIT_DIV) @(negedge clk);
				check_bit(on_com1, "stop bit", 1'b1);
				compare_byte(on_com1, rx_byte);
			end
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// stimulus

	task automatic print_counts();
		$display("checks %0d, errors %0d, tm frames %0d, btc frames %0d",
			checks, errors, tm_frames, btc_frames);
	endtask

	// only between frames, with both lines quiet
	task automatic change_line_settings();
		do
			@(posedge clk);
		while (!(tm_ready && quiet_cnt >= QUIET_CYC));
		btc     <= {8'($urandom), 32'($urandom)};
		btc_en  <= ($urandom % 4) != 0;
		com_src <= 1'($urandom);
	endtask

	always @(posedge clk)
	begin
		cycles++;
		if (cycles >= MAX_CYCLES)
		begin
			errors++;
			$display("run did not finish within %0d cycles, %0d bytes still expected",
				MAX_CYCLES, exp_q.size());
			print_counts();
			$display("** FAIL **");
			$finish;
		end
	end

	initial
	begin : stimulus
		int gap;
		void'($urandom(32'hdc30));
		clk      = 1'b0;
		n_rst    = 1'b0;
		tm_valid = 1'b0;
		tm_data  = '0;
		btc_en   = 1'b1;
		btc      = '0;
		com_src  = 1'b1;
		repeat (16) @(posedge clk);
		expect_bit("tm_ready", tm_ready, 1'b1);      // reset state
		expect_bit("com1", com1, 1'b1);
		expect_bit("com2", com2, 1'b1);
		n_rst <= 1'b1;
		repeat (4) @(posedge clk);
		for (int w = 0; w < N_WORDS; w++)
		begin
			gap = (($urandom % 5) == 0) ? int'($urandom % MAX_GAP) : int'($urandom % 3);
			repeat (gap) @(posedge clk);
			if (($urandom % 3) == 0)
				change_line_settings();
			tm_valid <= 1'b1;
			tm_data  <= $urandom;
			do
				@(posedge clk);
			while (!tm_ready);                      // held until accepted
			tm_valid <= 1'b0;
		end
		do
			@(posedge clk);
		while (!(tm_ready && quiet_cnt >= QUIET_CYC));
		checks++;
		if (exp_q.size() != 0)
		begin
			errors++;
			$display("%0d expected bytes never arrived on the line", exp_q.size());
		end
		print_counts();
		if (errors == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

// File: verilog.f
+incdir+verilog
verilog/hsi_line_pkg.sv
verilog/hsi_frame_pkg.sv
verilog/clk_en_ctrl.sv
verilog/msg_sender.sv
verilog/btc_sched.sv
verilog/crc16_ccitt.sv
verilog/bit_coder.sv
verilog/hsi_master.sv
verification/hsi_tb.sv

// File: Makefile
TOP = hsi_tb
LOG = sim.log

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): verilog.f $(wildcard verilog/*.sv verilog/*.svh verification/*.sv)
	verilator --binary --timing --assert -Wno-fatal -f verilog.f \
		--top-module $(TOP) -Mdir obj_dir

run: obj_dir/V$(TOP)
	obj_dir/V$(TOP) | tee $(LOG)
	grep -q '^\*\* PASS \*\*$$' $(LOG)

lint:
	verilator --lint-only --timing -Wall -f verilog.f --top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)
